//--- build.f
+incdir+.
wrbuf_types_pkg.sv
wrbuf_ctl_pkg.sv
wrbuf_buffer_manager.sv
wrbuf_data_ram.sv
wrbuf_dataid_tracker.sv
wrbuf_drain_sequencer.sv
wrbuf_top.sv
tb_clock_gen.sv
tb_wrbuf_top.sv

//--- run_sim.sh
#!/bin/sh
# build the write buffer testbench with verilator and run it
# the exit status of the run is the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary -f build.f --top-module tb_wrbuf_top -Mdir obj_dir -o tb_wrbuf_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_wrbuf_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

//--- tb_clock_gen.sv
module tb_clock_gen
(
    output logic ctl_clk,
    output logic ctl_reset_n
);

    // free running clock with a period of 10
    initial
    begin
        ctl_clk = 1'b0;
        forever
        begin
            #5 ctl_clk = ~ctl_clk;
        end
    end

    // reset held low for ten rising edges
    initial
    begin
        ctl_reset_n <= 1'b0;
        repeat (10)
        begin
            @(posedge ctl_clk);
        end
        ctl_reset_n <= 1'b1;
    end

endmodule

//--- tb_wrbuf_top.sv
`include "wrbuf_macros.svh"

module tb_wrbuf_top;
    import wrbuf_types_pkg::*;

    localparam int num_bursts     = 60;
    localparam int buf_depth      = 1 << `WRBUF_DEPTH_LOG2;
    localparam int slot_count     = 1 << `WRBUF_BURST_SLOTS_LOG2;
    localparam int timeout_cycles = num_bursts * `WRBUF_MAX_BURST * 8 + 200;

    logic        ctl_clk;
    logic        ctl_reset_n;
    logic        wr_valid;
    wrbuf_data_t wr_data;
    logic        wr_last;
    logic        wr_ready;
    logic        rd_valid;
    wrbuf_data_t rd_data;
    logic        rd_last;
    logic        rd_ready;
    logic        err_overflow;

    // reference model, one entry per accepted host beat
    wrbuf_data_t exp_data_q[$];
    logic        exp_last_q[$];

    int          beats_in      = 0;
    int          beats_closed  = 0;
    int          beats_out     = 0;
    int          bursts_closed = 0;
    int          bursts_out    = 0;
    int          cycle_count   = 0;
    logic        stalled       = 1'b0;
    wrbuf_data_t held_data;
    logic        held_last;

    tb_clock_gen clock_gen_i
    (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n)
    );

    wrbuf_top wrbuf_top_i
    (
        .ctl_clk      (ctl_clk),
        .ctl_reset_n  (ctl_reset_n),
        .wr_valid     (wr_valid),
        .wr_data      (wr_data),
        .wr_last      (wr_last),
        .wr_ready     (wr_ready),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .rd_last      (rd_last),
        .rd_ready     (rd_ready),
        .err_overflow (err_overflow)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compare
    (
        input logic [63:0] actual,
        input logic [63:0] expected,
        input string       what
    );
        if (actual !== expected)
        begin
            abort_run($sformatf("Mismatch at time %0t: %s (got 0x%0h, expected 0x%0h)",
                                $time, what, actual, expected));
        end
    endtask

    // monitor, everything sampled is the value from before this edge
    always @(posedge ctl_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            abort_run($sformatf("Timeout after %0d cycles, %0d of %0d bursts drained",
                                cycle_count, bursts_out, num_bursts));
        end
        if (ctl_reset_n)
        begin
            compare(64'(err_overflow), 64'd0, "err_overflow raised");
            // up to two already read beats sit in the skid or in flight
            compare(64'(exp_data_q.size() <= buf_depth + 2), 64'd1, "too many unread beats");
            if (exp_data_q.size() >= buf_depth + 2)
            begin
                compare(64'(wr_ready), 64'd0, "wr_ready high with a full buffer");
            end
            // at most three popped bursts can still be on their way out
            if (bursts_closed - bursts_out >= slot_count + 3)
            begin
                compare(64'(wr_ready), 64'd0, "wr_ready high with all records in use");
            end
            // memory port must hold still under back-pressure
            if (stalled)
            begin
                compare(64'(rd_valid), 64'd1, "rd_valid dropped while stalled");
                compare(64'(rd_data), 64'(held_data), "rd_data changed while stalled");
                compare(64'(rd_last), 64'(held_last), "rd_last changed while stalled");
            end
            stalled   = rd_valid && !rd_ready;
            held_data = rd_data;
            held_last = rd_last;
            // store and forward, the head beat's burst must be closed
            if (rd_valid)
            begin
                compare(64'(beats_out < beats_closed), 64'd1, "beat out before its wr_last");
            end
            if (rd_valid && rd_ready)
            begin
                if (exp_data_q.size() == 0)
                begin
                    abort_run("Memory side delivered a beat that was never written");
                end
                compare(64'(rd_data), 64'(exp_data_q[0]), "rd_data");
                compare(64'(rd_last), 64'(exp_last_q[0]), "rd_last");
                void'(exp_data_q.pop_front());
                void'(exp_last_q.pop_front());
                beats_out = beats_out + 1;
                if (rd_last)
                begin
                    bursts_out = bursts_out + 1;
                end
            end
            if (wr_valid && wr_ready)
            begin
                exp_data_q.push_back(wr_data);
                exp_last_q.push_back(wr_last);
                beats_in = beats_in + 1;
                if (wr_last)
                begin
                    beats_closed  = beats_in;
                    bursts_closed = bursts_closed + 1;
                end
            end
        end
    end

    // host bursts and back-pressure from one process, one draw order
    initial
    begin
        int cur_len;
        int beat_idx;
        int bursts_sent;
        int phase_kind;
        int phase_left;

        void'($urandom(32'h7fa4e1b3));
        wr_valid <= 1'b0;
        wr_data  <= '0;
        wr_last  <= 1'b0;
        rd_ready <= 1'b0;
        cur_len     = int'($urandom_range(1, `WRBUF_MAX_BURST));
        beat_idx    = 0;
        bursts_sent = 0;
        phase_kind  = 0;
        phase_left  = 0;

        @(posedge ctl_clk);
        while (!ctl_reset_n)
        begin
            @(posedge ctl_clk);
        end
        compare(64'(wr_ready), 64'd1, "wr_ready after reset");
        compare(64'(rd_valid), 64'd0, "rd_valid after reset");

        while (bursts_out < num_bursts)
        begin
            // 0 mostly ready, 1 long stall, 2 coin flip, 3 always ready
            if (phase_left == 0)
            begin
                phase_kind = int'($urandom_range(0, 3));
                phase_left = int'($urandom_range(10, 60));
            end
            phase_left = phase_left - 1;
            case (phase_kind)
                0: rd_ready <= ($urandom_range(0, 3) != 0);
                1: rd_ready <= 1'b0;
                2: rd_ready <= ($urandom_range(0, 1) == 1);
                default: rd_ready <= 1'b1;
            endcase

            // beat driven last cycle went through on this edge
            if (wr_valid && wr_ready)
            begin
                if (wr_last)
                begin
                    bursts_sent = bursts_sent + 1;
                    beat_idx    = 0;
                    cur_len     = int'($urandom_range(1, `WRBUF_MAX_BURST));
                end
                else
                begin
                    beat_idx = beat_idx + 1;
                end
            end
            // a stalled beat stays on the bus untouched
            if (!wr_valid || wr_ready)
            begin
                if (bursts_sent < num_bursts && $urandom_range(0, 3) != 0)
                begin
                    wr_valid <= 1'b1;
                    wr_data  <= wrbuf_data_t'($urandom());
                    wr_last  <= (beat_idx == cur_len - 1);
                end
                else
                begin
                    wr_valid <= 1'b0;
                end
            end
            @(posedge ctl_clk);
        end

        wr_valid <= 1'b0;
        @(negedge ctl_clk);
        if (exp_data_q.size() != 0)
        begin
            abort_run($sformatf("%0d written beats never reached the memory side",
                                exp_data_q.size()));
        end
        else
        begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- wrbuf_buffer_manager.sv
`include "wrbuf_macros.svh"

module wrbuf_buffer_manager
(
    input  logic                        ctl_clk,
    input  logic                        ctl_reset_n,
    input  logic                        writeif_valid,
    input  wrbuf_types_pkg::wrbuf_addr_t writeif_address,
    input  logic                        writeif_address_blocked,
    input  logic                        readif_valid,
    input  wrbuf_types_pkg::wrbuf_addr_t readif_address,
    output logic                        writeif_ready,
    output logic                        buffwrite_valid,
    output wrbuf_types_pkg::wrbuf_addr_t buffwrite_address,
    output logic                        buffread_valid,
    output wrbuf_types_pkg::wrbuf_addr_t buffread_address,
    output logic                        buffread_datavalid,
    output logic                        err_overflow
);
    import wrbuf_types_pkg::*;

    // number of buffer locations
    localparam wrbuf_count_t buf_depth = wrbuf_count_t'(1 << `WRBUF_DEPTH_LOG2);

    wrbuf_count_t buf_count;
    logic         writeif_accepted;

    // write goes through only on a valid/ready handshake
    assign writeif_accepted  = writeif_valid & writeif_ready;

    // addresses pass straight to the ram
    assign buffwrite_valid   = writeif_accepted;
    assign buffwrite_address = writeif_address;
    assign buffread_valid    = readif_valid;
    assign buffread_address  = readif_address;

    // stall when every location holds data
    // or when the tracker has no room for another burst
    assign writeif_ready = ~writeif_address_blocked & (buf_count != buf_depth);

    // ram read data lands one cycle after the address
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            buffread_datavalid <= 1'b0;
        end
        else
        begin
            buffread_datavalid <= buffread_valid;
        end
    end

    // occupancy counter
    // a location is freed as soon as its read is issued
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            buf_count    <= '0;
            err_overflow <= 1'b0;
        end
        else
        begin
            if (writeif_accepted && !readif_valid)
            begin
                // write only
                if (buf_count == buf_depth)
                begin
                    // sticky, only cleared by reset
                    err_overflow <= 1'b1;
                end
                buf_count <= buf_count + 1'b1;
            end
            else if (readif_valid && !writeif_accepted)
            begin
                // read only
                buf_count <= buf_count - 1'b1;
            end
            // write and read together leave the count alone
        end
    end

endmodule

//--- wrbuf_ctl_pkg.sv
package wrbuf_ctl_pkg;

    // drain sequencer states
    // idle waits for a burst record, stream issues its reads
    typedef enum logic
    {
        drain_idle,
        drain_stream
    } drain_state_t;

endpackage

//--- wrbuf_data_ram.sv
`include "wrbuf_macros.svh"

module wrbuf_data_ram
(
    input  logic                         ctl_clk,
    input  logic                         wr_en,
    input  wrbuf_types_pkg::wrbuf_addr_t wr_addr,
    input  wrbuf_types_pkg::wrbuf_data_t wr_data,
    input  logic                         rd_en,
    input  wrbuf_types_pkg::wrbuf_addr_t rd_addr,
    output wrbuf_types_pkg::wrbuf_data_t rd_data
);
    import wrbuf_types_pkg::*;

    // one entry per buffer location
    wrbuf_data_t mem [1 << `WRBUF_DEPTH_LOG2];

    // write port
    always_ff @(posedge ctl_clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read port, one cycle latency
    // same-address write in the same cycle gives the old word
    always_ff @(posedge ctl_clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- wrbuf_dataid_tracker.sv
`include "wrbuf_macros.svh"

module wrbuf_dataid_tracker
(
    input  logic                         ctl_clk,
    input  logic                         ctl_reset_n,
    input  logic                         buffwrite_valid,
    input  logic                         wr_last,
    input  logic                         rec_ready,
    output wrbuf_types_pkg::wrbuf_addr_t next_address,
    output logic                         address_blocked,
    output logic                         rec_valid,
    output wrbuf_types_pkg::wrbuf_addr_t rec_addr,
    output wrbuf_types_pkg::wrbuf_len_t  rec_len
);
    import wrbuf_types_pkg::*;

    localparam int slot_bits = `WRBUF_BURST_SLOTS_LOG2;

    wrbuf_addr_t          wr_ptr;
    wrbuf_addr_t          burst_start;
    wrbuf_len_t           burst_len;
    logic [slot_bits:0]   push_idx;
    logic [slot_bits:0]   pop_idx;
    logic                 rec_push;
    logic                 rec_pop;
    logic                 rec_full;

    // record storage, start address and length per burst
    wrbuf_addr_t slot_addr [1 << slot_bits];
    wrbuf_len_t  slot_len  [1 << slot_bits];

    assign next_address = wr_ptr;

    // last beat accepted closes the open burst
    assign rec_push = buffwrite_valid & wr_last;
    assign rec_pop  = rec_valid & rec_ready;

    // wrap bits differ, index bits match
    assign rec_full = (push_idx[slot_bits] != pop_idx[slot_bits]) &&
                      (push_idx[slot_bits-1:0] == pop_idx[slot_bits-1:0]);
    assign address_blocked = rec_full;
    assign rec_valid = (push_idx != pop_idx);

    assign rec_addr = slot_addr[pop_idx[slot_bits-1:0]];
    assign rec_len  = slot_len[pop_idx[slot_bits-1:0]];

    // write pointer and open burst bookkeeping
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            wr_ptr      <= '0;
            burst_start <= '0;
            burst_len   <= '0;
        end
        else if (buffwrite_valid)
        begin
            // addr_t width makes this wrap at the depth
            wr_ptr <= wr_ptr + 1'b1;
            if (wr_last)
            begin
                // next burst starts right behind this beat
                burst_start <= wr_ptr + 1'b1;
                burst_len   <= '0;
            end
            else
            begin
                burst_len <= burst_len + 1'b1;
            end
        end
    end

    // record fifo pointers
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            push_idx <= '0;
            pop_idx  <= '0;
        end
        else
        begin
            if (rec_push)
            begin
                push_idx <= push_idx + 1'b1;
            end
            if (rec_pop)
            begin
                pop_idx <= pop_idx + 1'b1;
            end
        end
    end

    // record payload, length counts the closing beat too
    always_ff @(posedge ctl_clk)
    begin
        if (rec_push)
        begin
            slot_addr[push_idx[slot_bits-1:0]] <= burst_start;
            slot_len[push_idx[slot_bits-1:0]]  <= burst_len + 1'b1;
        end
    end

endmodule

//--- wrbuf_drain_sequencer.sv
module wrbuf_drain_sequencer
(
    input  logic                         ctl_clk,
    input  logic                         ctl_reset_n,
    input  logic                         rec_valid,
    input  wrbuf_types_pkg::wrbuf_addr_t rec_addr,
    input  wrbuf_types_pkg::wrbuf_len_t  rec_len,
    input  logic                         buffread_datavalid,
    input  wrbuf_types_pkg::wrbuf_data_t ram_rd_data,
    input  logic                         rd_ready,
    output logic                         rec_ready,
    output logic                         readif_valid,
    output wrbuf_types_pkg::wrbuf_addr_t readif_address,
    output logic                         rd_valid,
    output wrbuf_types_pkg::wrbuf_data_t rd_data,
    output logic                         rd_last
);
    import wrbuf_types_pkg::*;
    import wrbuf_ctl_pkg::*;

    drain_state_t state;
    wrbuf_addr_t  rd_ptr;
    wrbuf_len_t   remaining;
    logic         inflight_last;
    logic         rec_pop;
    logic         skid_pop;
    logic [1:0]   skid_count;
    logic [2:0]   skid_used;
    logic         skid_wr_sel;
    logic         skid_rd_sel;

    // two-entry skid toward the memory port
    wrbuf_data_t skid_data [2];
    logic        skid_last [2];

    // only take a record once the previous burst is fully issued
    assign rec_ready = (state == drain_idle);
    assign rec_pop   = rec_valid & rec_ready;

    // held entries plus the beat returning now, less the one leaving
    assign skid_pop  = rd_valid & rd_ready;
    assign skid_used = {1'b0, skid_count} + {2'b0, buffread_datavalid} - {2'b0, skid_pop};

    // a new read may only go out if its data is sure to find room
    assign readif_valid   = (state == drain_stream) && (skid_used < 3'd2);
    assign readif_address = rd_ptr;

    // sequencer fsm
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            state         <= drain_idle;
            rd_ptr        <= '0;
            remaining     <= '0;
            inflight_last <= 1'b0;
        end
        else
        begin
            // last flag follows the read, lines up with buffread_datavalid
            inflight_last <= readif_valid && (remaining == wrbuf_len_t'(1));
            case (state)
                drain_idle:
                begin
                    if (rec_pop)
                    begin
                        rd_ptr    <= rec_addr;
                        remaining <= rec_len;
                        state     <= drain_stream;
                    end
                end
                drain_stream:
                begin
                    if (readif_valid)
                    begin
                        rd_ptr    <= rd_ptr + 1'b1;
                        remaining <= remaining - 1'b1;
                        // final beat of the burst issued
                        if (remaining == wrbuf_len_t'(1))
                        begin
                            state <= drain_idle;
                        end
                    end
                end
                default:
                begin
                    state <= drain_idle;
                end
            endcase
        end
    end

    // skid pointers and fill level
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            skid_count  <= '0;
            skid_wr_sel <= 1'b0;
            skid_rd_sel <= 1'b0;
        end
        else
        begin
            if (buffread_datavalid)
            begin
                skid_wr_sel <= ~skid_wr_sel;
            end
            if (skid_pop)
            begin
                skid_rd_sel <= ~skid_rd_sel;
            end
            skid_count <= skid_used[1:0];
        end
    end

    // skid payload
    always_ff @(posedge ctl_clk)
    begin
        if (buffread_datavalid)
        begin
            skid_data[skid_wr_sel] <= ram_rd_data;
            skid_last[skid_wr_sel] <= inflight_last;
        end
    end

    // head entry stays put until it is taken
    assign rd_valid = (skid_count != 2'd0);
    assign rd_data  = skid_data[skid_rd_sel];
    assign rd_last  = skid_last[skid_rd_sel];

endmodule

//--- wrbuf_macros.svh
`ifndef WRBUF_MACROS_SVH
`define WRBUF_MACROS_SVH

// log2 of buffer locations
`define WRBUF_DEPTH_LOG2 4

// bits per data beat
`define WRBUF_DATA_WIDTH 32

// log2 of burst records held by the tracker
`define WRBUF_BURST_SLOTS_LOG2 2

// longest legal host burst, in beats
`define WRBUF_MAX_BURST 8

`endif

//--- wrbuf_top.sv
module wrbuf_top
(
    input  logic                         ctl_clk,
    input  logic                         ctl_reset_n,
    input  logic                         wr_valid,
    input  wrbuf_types_pkg::wrbuf_data_t wr_data,
    input  logic                         wr_last,
    output logic                         wr_ready,
    output logic                         rd_valid,
    output wrbuf_types_pkg::wrbuf_data_t rd_data,
    output logic                         rd_last,
    input  logic                         rd_ready,
    output logic                         err_overflow
);
    import wrbuf_types_pkg::*;

    // tracker to manager
    wrbuf_addr_t next_address;
    logic        address_blocked;

    // manager to ram and tracker
    logic        buffwrite_valid;
    wrbuf_addr_t buffwrite_address;
    logic        buffread_valid;
    wrbuf_addr_t buffread_address;
    logic        buffread_datavalid;

    // tracker to drain records
    logic        rec_valid;
    logic        rec_ready;
    wrbuf_addr_t rec_addr;
    wrbuf_len_t  rec_len;

    // drain reads
    logic        readif_valid;
    wrbuf_addr_t readif_address;
    wrbuf_data_t ram_rd_data;

    wrbuf_buffer_manager buffer_manager_i
    (
        .ctl_clk                 (ctl_clk),
        .ctl_reset_n             (ctl_reset_n),
        .writeif_valid           (wr_valid),
        .writeif_address         (next_address),
        .writeif_address_blocked (address_blocked),
        .readif_valid            (readif_valid),
        .readif_address          (readif_address),
        .writeif_ready           (wr_ready),
        .buffwrite_valid         (buffwrite_valid),
        .buffwrite_address       (buffwrite_address),
        .buffread_valid          (buffread_valid),
        .buffread_address        (buffread_address),
        .buffread_datavalid      (buffread_datavalid),
        .err_overflow            (err_overflow)
    );

    // host data is written in the cycle it is accepted
    wrbuf_data_ram data_ram_i
    (
        .ctl_clk (ctl_clk),
        .wr_en   (buffwrite_valid),
        .wr_addr (buffwrite_address),
        .wr_data (wr_data),
        .rd_en   (buffread_valid),
        .rd_addr (buffread_address),
        .rd_data (ram_rd_data)
    );

    wrbuf_dataid_tracker dataid_tracker_i
    (
        .ctl_clk         (ctl_clk),
        .ctl_reset_n     (ctl_reset_n),
        .buffwrite_valid (buffwrite_valid),
        .wr_last         (wr_last),
        .rec_ready       (rec_ready),
        .next_address    (next_address),
        .address_blocked (address_blocked),
        .rec_valid       (rec_valid),
        .rec_addr        (rec_addr),
        .rec_len         (rec_len)
    );

    wrbuf_drain_sequencer drain_sequencer_i
    (
        .ctl_clk            (ctl_clk),
        .ctl_reset_n        (ctl_reset_n),
        .rec_valid          (rec_valid),
        .rec_addr           (rec_addr),
        .rec_len            (rec_len),
        .buffread_datavalid (buffread_datavalid),
        .ram_rd_data        (ram_rd_data),
        .rd_ready           (rd_ready),
        .rec_ready          (rec_ready),
        .readif_valid       (readif_valid),
        .readif_address     (readif_address),
        .rd_valid           (rd_valid),
        .rd_data            (rd_data),
        .rd_last            (rd_last)
    );

endmodule

//--- wrbuf_types_pkg.sv
`include "wrbuf_macros.svh"

package wrbuf_types_pkg;

    // one data beat
    typedef logic [`WRBUF_DATA_WIDTH-1:0] wrbuf_data_t;

    // buffer location
    typedef logic [`WRBUF_DEPTH_LOG2-1:0] wrbuf_addr_t;

    // occupancy, one extra bit so the full depth fits
    typedef logic [`WRBUF_DEPTH_LOG2:0] wrbuf_count_t;

    // burst length in beats, must hold the max burst itself
    typedef logic [$clog2(`WRBUF_MAX_BURST+1)-1:0] wrbuf_len_t;

endpackage
